// File: rtl/weight_rotator_pkg.sv
// ==========================================================
// weight rotator shared definitions
// widths, header field positions and FSM state encodings
// ==========================================================

package weight_rotator_pkg;

  localparam int N_BANKS = 2;   // ping-pong pair
  localparam int DATA_W  = 32;  // stream and bank word width
  localparam int DEPTH   = 16;  // entries per bank
  localparam int ADDR_W  = 4;
  localparam int CNT_W   = 4;   // header field and counter width

  // header word layout, higher bits ignored
  localparam int HDR_BEATS_LSB  = 0;
  localparam int HDR_COLS_LSB   = 4;
  localparam int HDR_BLOCKS_LSB = 8;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  typedef enum logic [1:0] {
    LOAD_HEADER,  // wait for header beat
    LOAD_WRITE,   // data beats into the write bank
    LOAD_COMMIT   // mark bank full, switch bank
  } load_state_e;

  typedef enum logic [1:0] {
    READ_IDLE,    // wait for read bank to fill
    READ_STREAM,  // rotate bank contents
    READ_RELEASE  // free bank, switch bank
  } read_state_e;

endpackage

// File: rtl/weight_loader.sv
// ==========================================================
// weight loader
// takes the header beat, then writes the data beats into
// the current write bank and hands it over on commit
// ==========================================================
`timescale 1ns/100ps

module weight_loader (
  input  logic                      aclk,
  input  logic                      i_arst_n,
  input  logic                      i_s_valid,
  input  weight_rotator_pkg::word_t i_s_data,
  input  logic                      i_full [weight_rotator_pkg::N_BANKS],
  output logic                      o_s_ready,
  output weight_rotator_pkg::addr_t o_wr_addr,
  output weight_rotator_pkg::word_t o_wr_data,
  output logic                      o_wr_en [weight_rotator_pkg::N_BANKS],
  output logic                      o_hdr_en [weight_rotator_pkg::N_BANKS],
  output logic                      o_commit [weight_rotator_pkg::N_BANKS]
);

  weight_rotator_pkg::load_state_e state_q;
  weight_rotator_pkg::cnt_t        beats_1_q;
  weight_rotator_pkg::addr_t       wr_addr_q;
  logic                            wr_idx;     // write-side ping-pong index
  logic                            s_hs;

  always_comb begin
    unique case (state_q)
      weight_rotator_pkg::LOAD_HEADER: o_s_ready = !i_full[wr_idx];  // hold off until bank is free
      weight_rotator_pkg::LOAD_WRITE:  o_s_ready = 1'b1;
      default:                         o_s_ready = 1'b0;
    endcase
  end

  assign s_hs      = i_s_valid && o_s_ready;
  assign o_wr_addr = wr_addr_q;
  assign o_wr_data = i_s_data;  // header and data share the write bus

  always_comb begin
    for (int i = 0; i < weight_rotator_pkg::N_BANKS; i++) begin
      o_hdr_en[i] = (i == wr_idx) && s_hs && (state_q == weight_rotator_pkg::LOAD_HEADER);
      o_wr_en[i]  = (i == wr_idx) && s_hs && (state_q == weight_rotator_pkg::LOAD_WRITE);
      o_commit[i] = (i == wr_idx) && (state_q == weight_rotator_pkg::LOAD_COMMIT);
    end
  end

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= weight_rotator_pkg::LOAD_HEADER;
      beats_1_q <= '0;
      wr_addr_q <= '0;
      wr_idx    <= 1'b0;
    end else begin
      unique case (state_q)
        weight_rotator_pkg::LOAD_HEADER: begin
          if (s_hs) begin
            beats_1_q <= i_s_data[weight_rotator_pkg::HDR_BEATS_LSB +: weight_rotator_pkg::CNT_W];
            wr_addr_q <= '0;
            state_q   <= weight_rotator_pkg::LOAD_WRITE;
          end
        end
        weight_rotator_pkg::LOAD_WRITE: begin
          if (s_hs) begin
            wr_addr_q <= wr_addr_q + 1'b1;
            if (wr_addr_q == beats_1_q) begin  // last data beat of the load
              state_q <= weight_rotator_pkg::LOAD_COMMIT;
            end
          end
        end
        weight_rotator_pkg::LOAD_COMMIT: begin
          wr_idx  <= !wr_idx;
          state_q <= weight_rotator_pkg::LOAD_HEADER;
        end
        default: state_q <= weight_rotator_pkg::LOAD_HEADER;
      endcase
    end
  end

endmodule

// File: rtl/weight_bank.sv
// ==========================================================
// weight bank
// word storage with asynchronous read, the reference fields
// of its load and a full flag shared by loader and reader
// ==========================================================
`timescale 1ns/100ps

module weight_bank (
  input  logic                      aclk,
  input  logic                      i_arst_n,
  input  logic                      i_wr_en,
  input  logic                      i_hdr_en,
  input  logic                      i_commit,
  input  logic                      i_release,
  input  weight_rotator_pkg::addr_t i_wr_addr,
  input  weight_rotator_pkg::word_t i_wr_data,
  input  weight_rotator_pkg::addr_t i_rd_addr,
  output weight_rotator_pkg::word_t o_rd_data,
  output logic                      o_full,
  output weight_rotator_pkg::cnt_t  o_beats_1,
  output weight_rotator_pkg::cnt_t  o_cols_1,
  output weight_rotator_pkg::cnt_t  o_blocks_1
);

  weight_rotator_pkg::word_t mem [weight_rotator_pkg::DEPTH];

  always_ff @(posedge aclk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  assign o_rd_data = mem[i_rd_addr];

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_beats_1  <= '0;
      o_cols_1   <= '0;
      o_blocks_1 <= '0;
    end else if (i_hdr_en) begin
      o_beats_1  <= i_wr_data[weight_rotator_pkg::HDR_BEATS_LSB  +: weight_rotator_pkg::CNT_W];
      o_cols_1   <= i_wr_data[weight_rotator_pkg::HDR_COLS_LSB   +: weight_rotator_pkg::CNT_W];
      o_blocks_1 <= i_wr_data[weight_rotator_pkg::HDR_BLOCKS_LSB +: weight_rotator_pkg::CNT_W];
    end
  end

  // set by the loader once written, cleared by the reader once rotated
  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_full <= 1'b0;
    end else if (i_commit) begin
      o_full <= 1'b1;
    end else if (i_release) begin
      o_full <= 1'b0;
    end
  end

endmodule

// File: rtl/weight_reader.sv
// ==========================================================
// weight reader
// replays the full read bank (cols x blocks) times through
// a registered master port, marks tlast and frees the bank
// ==========================================================
`timescale 1ns/100ps

module weight_reader (
  input  logic                      aclk,
  input  logic                      i_arst_n,
  input  logic                      i_full [weight_rotator_pkg::N_BANKS],
  input  weight_rotator_pkg::word_t i_rd_data [weight_rotator_pkg::N_BANKS],
  input  weight_rotator_pkg::cnt_t  i_beats_1 [weight_rotator_pkg::N_BANKS],
  input  weight_rotator_pkg::cnt_t  i_cols_1 [weight_rotator_pkg::N_BANKS],
  input  weight_rotator_pkg::cnt_t  i_blocks_1 [weight_rotator_pkg::N_BANKS],
  input  logic                      i_m_ready,
  output weight_rotator_pkg::addr_t o_rd_addr,
  output logic                      o_release [weight_rotator_pkg::N_BANKS],
  output logic                      o_m_valid,
  output weight_rotator_pkg::word_t o_m_data,
  output logic                      o_m_last
);

  weight_rotator_pkg::read_state_e state_q;
  weight_rotator_pkg::addr_t       addr_q;
  weight_rotator_pkg::cnt_t        col_q;
  weight_rotator_pkg::cnt_t        blk_q;
  weight_rotator_pkg::cnt_t        beats_1;
  weight_rotator_pkg::cnt_t        cols_1;
  weight_rotator_pkg::cnt_t        blocks_1;
  logic                            rd_idx;      // read-side ping-pong index
  logic                            issued_q;    // final beat already in the output register
  logic                            addr_wrap;
  logic                            col_wrap;
  logic                            last_issue;
  logic                            load;

  assign beats_1  = i_beats_1[rd_idx];
  assign cols_1   = i_cols_1[rd_idx];
  assign blocks_1 = i_blocks_1[rd_idx];

  assign addr_wrap  = (addr_q == beats_1);
  assign col_wrap   = (col_q == cols_1);
  assign last_issue = addr_wrap && col_wrap && (blk_q == blocks_1);

  // refill when empty or when the held beat leaves this cycle
  assign load = (state_q == weight_rotator_pkg::READ_STREAM) && !issued_q
             && (!o_m_valid || i_m_ready);

  assign o_rd_addr = addr_q;

  always_comb begin
    for (int i = 0; i < weight_rotator_pkg::N_BANKS; i++) begin
      o_release[i] = (i == rd_idx) && (state_q == weight_rotator_pkg::READ_RELEASE);
    end
  end

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q  <= weight_rotator_pkg::READ_IDLE;
      rd_idx   <= 1'b0;
      addr_q   <= '0;
      col_q    <= '0;
      blk_q    <= '0;
      issued_q <= 1'b0;
    end else begin
      unique case (state_q)
        weight_rotator_pkg::READ_IDLE: begin
          if (i_full[rd_idx]) begin
            state_q <= weight_rotator_pkg::READ_STREAM;
          end
        end
        weight_rotator_pkg::READ_STREAM: begin
          if (load) begin
            if (last_issue) begin
              issued_q <= 1'b1;
            end
            if (!addr_wrap) begin
              addr_q <= addr_q + 1'b1;
            end else begin
              addr_q <= '0;
              if (col_wrap) begin  // one column pass done over all columns
                col_q <= '0;
                blk_q <= blk_q + 1'b1;
              end else begin
                col_q <= col_q + 1'b1;
              end
            end
          end
          if (o_m_valid && i_m_ready && o_m_last) begin
            state_q <= weight_rotator_pkg::READ_RELEASE;
          end
        end
        weight_rotator_pkg::READ_RELEASE: begin
          rd_idx   <= !rd_idx;
          addr_q   <= '0;
          col_q    <= '0;
          blk_q    <= '0;
          issued_q <= 1'b0;
          state_q  <= weight_rotator_pkg::READ_IDLE;
        end
        default: state_q <= weight_rotator_pkg::READ_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_m_valid <= 1'b0;
      o_m_last  <= 1'b0;
    end else if (load) begin
      o_m_valid <= 1'b1;
      o_m_last  <= last_issue;
    end else if (i_m_ready) begin
      o_m_valid <= 1'b0;
      o_m_last  <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      o_m_data <= i_rd_data[rd_idx];
    end
  end

endmodule

// File: rtl/axis_weight_rotator.sv
// ==========================================================
// streaming weight rotator, top level
// loader fills one bank of a ping-pong pair while the
// reader rotates the other onto the master stream
// ==========================================================
`timescale 1ns/100ps

module axis_weight_rotator (
  input  logic                      aclk,
  input  logic                      i_arst_n,
  input  logic                      i_s_valid,
  input  weight_rotator_pkg::word_t i_s_data,
  input  logic                      i_m_ready,
  output logic                      o_s_ready,
  output logic                      o_m_valid,
  output weight_rotator_pkg::word_t o_m_data,
  output logic                      o_m_last
);

  weight_rotator_pkg::addr_t wr_addr;
  weight_rotator_pkg::word_t wr_data;
  weight_rotator_pkg::addr_t rd_addr;
  logic                      wr_en    [weight_rotator_pkg::N_BANKS];
  logic                      hdr_en   [weight_rotator_pkg::N_BANKS];
  logic                      commit   [weight_rotator_pkg::N_BANKS];
  logic                      release_ [weight_rotator_pkg::N_BANKS];
  logic                      full     [weight_rotator_pkg::N_BANKS];
  weight_rotator_pkg::word_t rd_data  [weight_rotator_pkg::N_BANKS];
  weight_rotator_pkg::cnt_t  beats_1  [weight_rotator_pkg::N_BANKS];
  weight_rotator_pkg::cnt_t  cols_1   [weight_rotator_pkg::N_BANKS];
  weight_rotator_pkg::cnt_t  blocks_1 [weight_rotator_pkg::N_BANKS];

  weight_loader weight_loader_i (
    .aclk      (aclk),
    .i_arst_n  (i_arst_n),
    .i_s_valid (i_s_valid),
    .i_s_data  (i_s_data),
    .i_full    (full),
    .o_s_ready (o_s_ready),
    .o_wr_addr (wr_addr),
    .o_wr_data (wr_data),
    .o_wr_en   (wr_en),
    .o_hdr_en  (hdr_en),
    .o_commit  (commit)
  );

  for (genvar g = 0; g < weight_rotator_pkg::N_BANKS; g++) begin : g_bank
    weight_bank weight_bank_i (
      .aclk       (aclk),
      .i_arst_n   (i_arst_n),
      .i_wr_en    (wr_en[g]),
      .i_hdr_en   (hdr_en[g]),
      .i_commit   (commit[g]),
      .i_release  (release_[g]),
      .i_wr_addr  (wr_addr),
      .i_wr_data  (wr_data),
      .i_rd_addr  (rd_addr),
      .o_rd_data  (rd_data[g]),
      .o_full     (full[g]),
      .o_beats_1  (beats_1[g]),
      .o_cols_1   (cols_1[g]),
      .o_blocks_1 (blocks_1[g])
    );
  end

  weight_reader weight_reader_i (
    .aclk       (aclk),
    .i_arst_n   (i_arst_n),
    .i_full     (full),
    .i_rd_data  (rd_data),
    .i_beats_1  (beats_1),
    .i_cols_1   (cols_1),
    .i_blocks_1 (blocks_1),
    .i_m_ready  (i_m_ready),
    .o_rd_addr  (rd_addr),
    .o_release  (release_),
    .o_m_valid  (o_m_valid),
    .o_m_data   (o_m_data),
    .o_m_last   (o_m_last)
  );

endmodule

// File: testbench/weight_rotator_assertions.sv
// ==========================================================
// weight rotator stream checks
// master beat stability under back-pressure and reset state
// ==========================================================
`timescale 1ns/100ps

module weight_rotator_assertions (
  input logic                      aclk,
  input logic                      i_arst_n,
  input logic                      o_m_valid,
  input logic                      i_m_ready,
  input logic                      o_m_last,
  input weight_rotator_pkg::word_t o_m_data
);

  int fail_count = 0;  // read by the testbench at the end of the run

  a_hold_stable: assert property (@(posedge aclk) disable iff (!i_arst_n)
    o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_data) && $stable(o_m_last))
    else begin
      fail_count++;
      $error("master beat changed while stalled");
    end

  a_reset_idle: assert property (@(posedge aclk) !i_arst_n |-> !o_m_valid)
    else begin
      fail_count++;
      $error("o_m_valid high during reset");
    end

  a_last_valid: assert property (@(posedge aclk) disable iff (!i_arst_n)
    o_m_last |-> o_m_valid)
    else begin
      fail_count++;
      $error("o_m_last high without o_m_valid");
    end

endmodule

bind axis_weight_rotator weight_rotator_assertions weight_rotator_assertions_i (.*);

// File: testbench/tb_axis_weight_rotator.sv
// ==========================================================
// testbench for the streaming weight rotator
// loads from a case file, per-beat scoreboard and timeout
// ==========================================================
`timescale 1ns/100ps

module tb_axis_weight_rotator;

  localparam int MAX_CASES = 32;
  localparam int FIELDS    = 6;  // beats_1 cols_1 blocks_1 base stall count

  logic        aclk = 1'b0;
  logic        i_arst_n;
  logic        i_s_valid;
  logic [31:0] i_s_data;
  logic        i_m_ready;
  logic        o_s_ready;
  logic        o_m_valid;
  logic [31:0] o_m_data;
  logic        o_m_last;

  logic [31:0] case_mem [FIELDS*MAX_CASES];
  logic [31:0] exp_data_q [$];
  logic        exp_last_q [$];
  int          n_cases      = 0;
  int          err_count    = 0;
  int          cases_failed = 0;
  int          cycle_count  = 0;
  int          cycle_limit  = 0;

  axis_weight_rotator axis_weight_rotator_i (
    .aclk      (aclk),
    .i_arst_n  (i_arst_n),
    .i_s_valid (i_s_valid),
    .i_s_data  (i_s_data),
    .i_m_ready (i_m_ready),
    .o_s_ready (o_s_ready),
    .o_m_valid (o_m_valid),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last)
  );

  always #50 aclk = !aclk;  // 100 ns period

  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the output stream did not finish", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic int case_field(input int c, input int f);
    return int'(case_mem[FIELDS*c + f]);
  endfunction

  // one beat on the slave port, returns 1 ns after the edge it transferred on
  task automatic send_word(input logic [31:0] word);
    i_s_valid = 1'b1;
    i_s_data  = word;
    @(negedge aclk);
    while (!o_s_ready) @(negedge aclk);  // stalled while the write bank is full
    @(posedge aclk);
    #1;
  endtask

  task automatic send_case(input int c);
    int          beats_1;
    int          cols_1;
    int          blocks_1;
    int          reps;
    logic [31:0] base;
    logic [31:0] hdr;
    beats_1  = case_field(c, 0);
    cols_1   = case_field(c, 1);
    blocks_1 = case_field(c, 2);
    base     = case_mem[FIELDS*c + 3];
    reps     = (cols_1 + 1) * (blocks_1 + 1);
    hdr        = $urandom;  // bits above the fields are don't care
    hdr[3:0]   = beats_1[3:0];
    hdr[7:4]   = cols_1[3:0];
    hdr[11:8]  = blocks_1[3:0];
    send_word(hdr);
    for (int k = 0; k <= beats_1; k++) begin
      send_word(base + k);
    end
    // expected beats exist only once the whole load has gone in
    for (int r = 0; r < reps; r++) begin
      for (int k = 0; k <= beats_1; k++) begin
        exp_data_q.push_back(base + k);
        exp_last_q.push_back(r == reps - 1 && k == beats_1);
      end
    end
  endtask

  task automatic check_case(input int c);
    int          n_exp;
    int          got;
    int          errs_at_start;
    logic [31:0] exp_data;
    logic        exp_last;
    n_exp         = (case_field(c, 0) + 1) * (case_field(c, 1) + 1) * (case_field(c, 2) + 1);
    errs_at_start = err_count;
    got           = 0;
    assert (n_exp == case_field(c, 5)) else begin
      err_count++;
      $display("** Error at %0t: case %0d beat count %0d in file, %0d from header fields",
               $time, c, case_field(c, 5), n_exp);
    end
    while (got < n_exp) begin
      @(posedge aclk);
      #1;
      i_m_ready = (case_field(c, 4) == 0) || ($urandom % 2 == 0);
      @(negedge aclk);
      if (o_m_valid && i_m_ready) begin
        if (exp_data_q.size() == 0) begin
          err_count++;
          $display("case %0d: an output beat arrived before its load was sent", c);
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_last = exp_last_q.pop_front();
          assert (o_m_data == exp_data) else begin
            err_count++;
            $display("** Error at %0t: case %0d beat %0d data %h, expected %h",
                     $time, c, got, o_m_data, exp_data);
          end
          assert (o_m_last == exp_last) else begin
            err_count++;
            $display("** Error at %0t: case %0d beat %0d last %b, expected %b",
                     $time, c, got, o_m_last, exp_last);
          end
        end
        got++;
      end
    end
    if (err_count == errs_at_start) begin
      $display("case %0d: passed, %0d beats", c, got);
    end else begin
      cases_failed++;
      $display("case %0d: failed, %0d errors", c, err_count - errs_at_start);
    end
  endtask

  initial begin
    void'($urandom(11));
    i_arst_n  = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_m_ready = 1'b0;
    foreach (case_mem[i]) case_mem[i] = '1;  // all ones marks the end of the file
    $readmemh("testbench/weight_rotator_cases.txt", case_mem);
    while (n_cases < MAX_CASES && case_mem[FIELDS*n_cases] !== '1) n_cases++;
    for (int c = 0; c < n_cases; c++) begin
      cycle_limit += case_field(c, 0) + 2 + case_field(c, 5);
    end
    cycle_limit = 4 * cycle_limit + 100;
    repeat (2) @(posedge aclk);
    #1;
    i_arst_n = 1'b1;
    @(negedge aclk);
    assert (!o_m_valid && o_s_ready) else begin
      err_count++;
      $display("** Error at %0t: after reset o_m_valid=%b o_s_ready=%b, expected 0 and 1",
               $time, o_m_valid, o_s_ready);
    end
    @(posedge aclk);
    #1;
    if (n_cases == 0) begin
      err_count++;
      $display("no test cases could be read from the case file");
    end
    fork
      begin
        for (int c = 0; c < n_cases; c++) send_case(c);
        i_s_valid = 1'b0;
      end
      begin
        for (int c = 0; c < n_cases; c++) check_case(c);
      end
    join
    i_m_ready = 1'b1;
    repeat (4) @(negedge aclk);
    assert (!o_m_valid) else begin
      err_count++;
      $display("** Error at %0t: extra output beat after the last case", $time);
    end
    $display("cases %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
             n_cases, n_cases - cases_failed, cases_failed, err_count,
             axis_weight_rotator_i.weight_rotator_assertions_i.fail_count);
    if (err_count == 0 && axis_weight_rotator_i.weight_rotator_assertions_i.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/weight_rotator_cases.txt
// one case per line, all values hex:
// beats_1 cols_1 blocks_1 data_base stall_mode(0 ready, 1 random) expected_beats
3 0 0 00001000 0 4
f 0 0 10000000 0 10
2 1 2 20000000 0 12
1 3 1 30000000 1 10
4 2 1 40000000 1 1e
0 0 0 50000000 0 1
0 2 3 60000000 1 c
7 1 1 70000000 0 20
5 0 0 80000000 1 6
2 0 0 90000000 0 3
f 1 0 a0000000 1 20
1 1 1 b0000000 0 8
3 2 2 c0000000 1 24
0 0 0 d0000000 0 1
f f 0 e0000000 0 100
2 0 1 f0000000 1 6
0 0 0 ffffffff 0 1

// File: sim.f
rtl/weight_rotator_pkg.sv
rtl/weight_loader.sv
rtl/weight_bank.sv
rtl/weight_reader.sv
rtl/axis_weight_rotator.sv
testbench/weight_rotator_assertions.sv
testbench/tb_axis_weight_rotator.sv

// File: Makefile
SIM      ?= verilator
TOP      ?= tb_axis_weight_rotator
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir
FLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
